// File: common/pinmux_pkg.sv
package pinmux_pkg;

  // --------------------
  // Bus widths
  // --------------------
  localparam int DATA_W = 32;
  localparam int BE_W   = 4;
  localparam int ADDR_W = 8;
  // Word index from address bits 6:2
  localparam int IDX_W  = 5;

  // --------------------
  // Word map
  // --------------------
  localparam logic [IDX_W-1:0] IDX_CHIP_ID    = 5'd0;
  localparam logic [IDX_W-1:0] IDX_GLBL_CTRL  = 5'd1;
  localparam logic [IDX_W-1:0] IDX_GLBL_CFG   = 5'd2;
  localparam logic [IDX_W-1:0] IDX_IRQ_MASK   = 5'd3;
  localparam logic [IDX_W-1:0] IDX_IRQ_STAT   = 5'd4;
  localparam logic [IDX_W-1:0] IDX_GPIO_IN    = 5'd5;
  localparam logic [IDX_W-1:0] IDX_GPIO_OUT   = 5'd6;
  localparam logic [IDX_W-1:0] IDX_GPIO_DIR   = 5'd7;
  // Word 8 dropped, reads zero
  localparam logic [IDX_W-1:0] IDX_GPIO_ISTAT = 5'd9;
  localparam logic [IDX_W-1:0] IDX_GPIO_ISET  = 5'd10;
  localparam logic [IDX_W-1:0] IDX_GPIO_IMASK = 5'd11;

  // Manufacturer 8268, two cores, chip 3, revision 1
  localparam logic [DATA_W-1:0] CHIP_ID_VAL = 32'h8268_2301;

  // Sticky hardware sources in status byte 1
  localparam int HW_IRQ_W = 8;

  // --------------------
  // Bus write side
  // --------------------
  // One select per writable register
  typedef struct packed {
    logic glbl_ctrl;
    logic glbl_cfg;
    logic irq_mask;
    logic irq_stat;
    logic gpio_out;
    logic gpio_dir;
    logic gpio_istat;
    logic gpio_iset;
    logic gpio_imask;
  } reg_sel_t;

  typedef struct packed {
    reg_sel_t              sel;
    // Write seen in its acknowledge cycle, once per access
    logic                  commit;
    logic [DATA_W-1:0]     wdata;
    logic [BE_W-1:0]       be;
  } reg_wr_t;

  // --------------------
  // Global control word
  // --------------------
  typedef struct packed {
    logic [21:0] spare_hi;
    logic [1:0]  cpu_core_rst_n;
    logic        spare_7;
    logic        uart1_rst_n;
    logic        usb_rst_n;
    logic        i2cm_rst_n;
    logic        uart0_rst_n;
    logic        sspim_rst_n;
    logic        qspim_rst_n;
    logic        cpu_intf_rst_n;
  } glbl_ctrl_t;

  // Same word seen raw for bus access or as reset fields
  typedef union packed {
    logic [DATA_W-1:0] raw;
    glbl_ctrl_t        f;
  } glbl_ctrl_u;

  // Block resets, all active low
  typedef struct packed {
    logic [1:0] cpu_core_rst_n;
    logic       cpu_intf_rst_n;
    logic       qspim_rst_n;
    logic       sspim_rst_n;
    logic       uart0_rst_n;
    logic       i2cm_rst_n;
    logic       usb_rst_n;
    logic       uart1_rst_n;
  } rst_ctrl_t;

  typedef struct packed {
    logic [15:0] irq_lines;
    logic        soft_irq;
    logic [2:0]  user_irq;
  } riscv_irq_t;

  typedef struct packed {
    logic [9:0]  pulse_1us;
    logic [15:0] riscv_ctrl;
  } glbl_cfg_t;

  typedef struct packed {
    logic [DATA_W-1:0] out_data;
    logic [DATA_W-1:0] dir_sel;
    logic [DATA_W-1:0] data_in;
    logic [DATA_W-1:0] prev_indata;
  } gpio_cfg_t;

  // Readable words into the read mux, set word aliases status
  typedef struct packed {
    logic [DATA_W-1:0] chip_id;
    logic [DATA_W-1:0] glbl_ctrl;
    logic [DATA_W-1:0] glbl_cfg;
    logic [DATA_W-1:0] irq_mask;
    logic [DATA_W-1:0] irq_stat;
    logic [DATA_W-1:0] gpio_in;
    logic [DATA_W-1:0] gpio_out;
    logic [DATA_W-1:0] gpio_dir;
    logic [DATA_W-1:0] gpio_istat;
    logic [DATA_W-1:0] gpio_imask;
  } reg_words_t;

  // Byte enables widened to a bit mask
  function automatic logic [DATA_W-1:0] be_mask(input logic [BE_W-1:0] be);
    logic [DATA_W-1:0] m;
    for (int b = 0; b < BE_W; b++) begin
      m[8*b +: 8] = {8{be[b]}};
    end
    return m;
  endfunction

  // Old word with the enabled bytes replaced
  function automatic logic [DATA_W-1:0] be_merge(
    input logic [DATA_W-1:0] old_val,
    input logic [DATA_W-1:0] new_val,
    input logic [BE_W-1:0]   be
  );
    logic [DATA_W-1:0] m;
    m = be_mask(be);
    return (old_val & ~m) | (new_val & m);
  endfunction

endpackage

// File: design/reg_bus_decode.sv
`timescale 1ns/1ps

module reg_bus_decode (
  input  logic                          mclk,
  input  logic                          h_reset_n,
  input  logic                          reg_cs,
  input  logic                          reg_wr,
  input  logic [pinmux_pkg::ADDR_W-1:0] reg_addr,
  input  logic [pinmux_pkg::DATA_W-1:0] reg_wdata,
  input  logic [pinmux_pkg::BE_W-1:0]   reg_be,
  output logic                          reg_ack,
  output pinmux_pkg::reg_wr_t           wr,
  output logic [pinmux_pkg::IDX_W-1:0]  rd_idx,
  output logic                          rd_capture
);

  logic [pinmux_pkg::IDX_W-1:0] idx;
  logic                         wr_en;

  // Word index, address bit 7 ignored
  assign idx   = reg_addr[pinmux_pkg::IDX_W+1:2];
  assign wr_en = reg_cs & reg_wr;

  // --------------------
  // Write selects
  // --------------------
  always_comb begin
    wr.sel.glbl_ctrl  = wr_en & (idx == pinmux_pkg::IDX_GLBL_CTRL);
    wr.sel.glbl_cfg   = wr_en & (idx == pinmux_pkg::IDX_GLBL_CFG);
    wr.sel.irq_mask   = wr_en & (idx == pinmux_pkg::IDX_IRQ_MASK);
    wr.sel.irq_stat   = wr_en & (idx == pinmux_pkg::IDX_IRQ_STAT);
    wr.sel.gpio_out   = wr_en & (idx == pinmux_pkg::IDX_GPIO_OUT);
    wr.sel.gpio_dir   = wr_en & (idx == pinmux_pkg::IDX_GPIO_DIR);
    wr.sel.gpio_istat = wr_en & (idx == pinmux_pkg::IDX_GPIO_ISTAT);
    wr.sel.gpio_iset  = wr_en & (idx == pinmux_pkg::IDX_GPIO_ISET);
    wr.sel.gpio_imask = wr_en & (idx == pinmux_pkg::IDX_GPIO_IMASK);
    // Second cycle of the access, for one-shot set and clear
    wr.commit         = wr_en & reg_ack;
    wr.wdata          = reg_wdata;
    wr.be             = reg_be;
  end

  // --------------------
  // Acknowledge
  // --------------------
  // First cycle of an access, read word captured here
  assign rd_capture = reg_cs & ~reg_ack;
  assign rd_idx     = idx;

  // Held reg_cs toggles ack, one access per two cycles
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      reg_ack <= 1'b0;
    end else begin
      reg_ack <= rd_capture;
    end
  end

  // At most one register written per cycle
  a_sel_onehot: assert property (@(posedge mclk) disable iff (!h_reset_n)
    $onehot0(wr.sel));

  // Ack is a single-cycle pulse even with reg_cs held
  a_ack_pulse: assert property (@(posedge mclk) disable iff (!h_reset_n)
    reg_ack |=> !reg_ack);

endmodule

// File: glbl_cfg/glbl_cfg_regs.sv
`timescale 1ns/1ps

module glbl_cfg_regs (
  input  logic                          mclk,
  input  logic                          h_reset_n,
  input  pinmux_pkg::reg_wr_t           wr,
  input  logic [1:0]                    ext_intr_in,
  input  logic                          usb_intr,
  input  logic                          i2cm_intr,
  input  logic [2:0]                    timer_intr,
  input  logic                          gpio_intr,
  output pinmux_pkg::rst_ctrl_t         rst_ctrl,
  output pinmux_pkg::glbl_cfg_t         glbl_cfg,
  output pinmux_pkg::riscv_irq_t        riscv_irq,
  output logic [pinmux_pkg::DATA_W-1:0] chip_id_word,
  output logic [pinmux_pkg::DATA_W-1:0] glbl_ctrl_word,
  output logic [pinmux_pkg::DATA_W-1:0] glbl_cfg_word,
  output logic [pinmux_pkg::DATA_W-1:0] irq_mask_word,
  output logic [pinmux_pkg::DATA_W-1:0] irq_stat_word
);

  pinmux_pkg::glbl_ctrl_u          ctrl_q;
  logic [pinmux_pkg::DATA_W-1:0]   cfg_q;
  logic [pinmux_pkg::DATA_W-1:0]   mask_q;
  logic [7:0]                      stat_sw_lo;
  logic [pinmux_pkg::HW_IRQ_W-1:0] stat_hw;
  logic [3:0]                      stat_sw_hi;
  logic [pinmux_pkg::HW_IRQ_W-1:0] hw_req;
  logic [pinmux_pkg::HW_IRQ_W-1:0] hw_clr;

  // --------------------
  // Control, config, mask
  // --------------------
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      ctrl_q.raw <= '0;
      cfg_q      <= '0;
      mask_q     <= '0;
    end else begin
      if (wr.sel.glbl_ctrl) begin
        ctrl_q.raw <= pinmux_pkg::be_merge(ctrl_q.raw, wr.wdata, wr.be);
      end
      if (wr.sel.glbl_cfg) begin
        cfg_q <= pinmux_pkg::be_merge(cfg_q, wr.wdata, wr.be);
      end
      if (wr.sel.irq_mask) begin
        mask_q <= pinmux_pkg::be_merge(mask_q, wr.wdata, wr.be);
      end
    end
  end

  // Reset fields straight from the control word
  assign rst_ctrl = '{
    cpu_core_rst_n: ctrl_q.f.cpu_core_rst_n,
    cpu_intf_rst_n: ctrl_q.f.cpu_intf_rst_n,
    qspim_rst_n:    ctrl_q.f.qspim_rst_n,
    sspim_rst_n:    ctrl_q.f.sspim_rst_n,
    uart0_rst_n:    ctrl_q.f.uart0_rst_n,
    i2cm_rst_n:     ctrl_q.f.i2cm_rst_n,
    usb_rst_n:      ctrl_q.f.usb_rst_n,
    uart1_rst_n:    ctrl_q.f.uart1_rst_n
  };

  // Pulse count low, RISC-V control in the top half
  assign glbl_cfg = '{pulse_1us: cfg_q[9:0], riscv_ctrl: cfg_q[31:16]};

  // --------------------
  // Interrupt status
  // --------------------
  // Source order, high bit first
  assign hw_req = {gpio_intr, ext_intr_in, usb_intr, i2cm_intr, timer_intr};

  // Write-1 clear of byte 1, once per access
  assign hw_clr = (wr.commit && wr.sel.irq_stat && wr.be[1]) ? wr.wdata[15:8] : '0;

  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      stat_sw_lo <= '0;
      stat_hw    <= '0;
      stat_sw_hi <= '0;
    end else begin
      // Bytes 0 and 2 are plain software bits
      if (wr.sel.irq_stat && wr.be[0]) begin
        stat_sw_lo <= wr.wdata[7:0];
      end
      if (wr.sel.irq_stat && wr.be[2]) begin
        stat_sw_hi <= wr.wdata[19:16];
      end
      // Hardware set beats software clear
      stat_hw <= (stat_hw & ~hw_clr) | hw_req;
    end
  end

  // Masked interrupt lines to the core
  assign riscv_irq = '{
    irq_lines: mask_q[15:0] & irq_stat_word[15:0],
    soft_irq:  mask_q[16] & irq_stat_word[16],
    user_irq:  mask_q[19:17] & irq_stat_word[19:17]
  };

  // Readback words
  assign chip_id_word   = pinmux_pkg::CHIP_ID_VAL;
  assign glbl_ctrl_word = ctrl_q.raw;
  assign glbl_cfg_word  = cfg_q;
  assign irq_mask_word  = mask_q;
  assign irq_stat_word  = {12'h0, stat_sw_hi, stat_hw, stat_sw_lo};

  // A line the bus sees as masked never reaches the core
  a_irq_masked: assert property (@(posedge mclk) disable iff (!h_reset_n)
    (riscv_irq.irq_lines & ~irq_mask_word[15:0]) == '0);

endmodule

// File: gpio/gpio_regs.sv
`timescale 1ns/1ps

module gpio_regs (
  input  logic                          mclk,
  input  logic                          h_reset_n,
  input  pinmux_pkg::reg_wr_t           wr,
  input  logic [pinmux_pkg::DATA_W-1:0] gpio_in_data,
  input  logic [pinmux_pkg::DATA_W-1:0] gpio_int_event,
  output pinmux_pkg::gpio_cfg_t         gpio_cfg,
  output logic                          gpio_intr,
  output logic [pinmux_pkg::DATA_W-1:0] gpio_in_word,
  output logic [pinmux_pkg::DATA_W-1:0] gpio_out_word,
  output logic [pinmux_pkg::DATA_W-1:0] gpio_dir_word,
  output logic [pinmux_pkg::DATA_W-1:0] gpio_istat_word,
  output logic [pinmux_pkg::DATA_W-1:0] gpio_imask_word
);

  logic [pinmux_pkg::DATA_W-1:0] in_s;
  logic [pinmux_pkg::DATA_W-1:0] in_ss;
  logic [pinmux_pkg::DATA_W-1:0] in_q;
  logic [pinmux_pkg::DATA_W-1:0] out_q;
  logic [pinmux_pkg::DATA_W-1:0] dir_q;
  logic [pinmux_pkg::DATA_W-1:0] imask_q;
  logic [pinmux_pkg::DATA_W-1:0] istat_q;
  logic [pinmux_pkg::DATA_W-1:0] istat_set;
  logic [pinmux_pkg::DATA_W-1:0] istat_clr;

  // --------------------
  // Input synchroniser
  // --------------------
  // Two flops for metastability, third holds the readable copy
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      in_s  <= '0;
      in_ss <= '0;
      in_q  <= '0;
    end else begin
      in_s  <= gpio_in_data;
      in_ss <= in_s;
      in_q  <= in_ss;
    end
  end

  // --------------------
  // Output, direction, mask
  // --------------------
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      out_q   <= '0;
      dir_q   <= '0;
      imask_q <= '0;
    end else begin
      if (wr.sel.gpio_out) begin
        out_q <= pinmux_pkg::be_merge(out_q, wr.wdata, wr.be);
      end
      if (wr.sel.gpio_dir) begin
        dir_q <= pinmux_pkg::be_merge(dir_q, wr.wdata, wr.be);
      end
      if (wr.sel.gpio_imask) begin
        imask_q <= pinmux_pkg::be_merge(imask_q, wr.wdata, wr.be);
      end
    end
  end

  // --------------------
  // Interrupt status
  // --------------------
  // Set from pin events or write-1 to the set word
  assign istat_set = gpio_int_event |
                     ((wr.commit && wr.sel.gpio_iset) ? wr.wdata : '0);

  // Write-1 clear, each byte under its own enable
  assign istat_clr = (wr.commit && wr.sel.gpio_istat) ?
                     (wr.wdata & pinmux_pkg::be_mask(wr.be)) : '0;

  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      istat_q <= '0;
    end else begin
      // Event posting wins over host clear
      istat_q <= (istat_q & ~istat_clr) | istat_set;
    end
  end

  // Combined interrupt to the global block
  assign gpio_intr = |(istat_q & imask_q);

  assign gpio_cfg = '{
    out_data:    out_q,
    dir_sel:     dir_q,
    data_in:     in_q,
    prev_indata: in_ss
  };

  // Readback words
  assign gpio_in_word    = in_q;
  assign gpio_out_word   = out_q;
  assign gpio_dir_word   = dir_q;
  assign gpio_istat_word = istat_q;
  assign gpio_imask_word = imask_q;

  // Interrupt only with a pending unmasked status bit
  a_intr_source: assert property (@(posedge mclk) disable iff (!h_reset_n)
    gpio_intr |-> |(gpio_istat_word & gpio_imask_word));

endmodule

// File: design/reg_read_mux.sv
`timescale 1ns/1ps

module reg_read_mux (
  input  logic                          mclk,
  input  logic                          h_reset_n,
  input  logic [pinmux_pkg::IDX_W-1:0]  rd_idx,
  input  logic                          rd_capture,
  input  pinmux_pkg::reg_words_t        words,
  output logic [pinmux_pkg::DATA_W-1:0] reg_rdata
);

  logic [pinmux_pkg::DATA_W-1:0] rd_word;

  // --------------------
  // Word select
  // --------------------
  always_comb begin
    case (rd_idx)
      pinmux_pkg::IDX_CHIP_ID:    rd_word = words.chip_id;
      pinmux_pkg::IDX_GLBL_CTRL:  rd_word = words.glbl_ctrl;
      pinmux_pkg::IDX_GLBL_CFG:   rd_word = words.glbl_cfg;
      pinmux_pkg::IDX_IRQ_MASK:   rd_word = words.irq_mask;
      pinmux_pkg::IDX_IRQ_STAT:   rd_word = words.irq_stat;
      pinmux_pkg::IDX_GPIO_IN:    rd_word = words.gpio_in;
      pinmux_pkg::IDX_GPIO_OUT:   rd_word = words.gpio_out;
      pinmux_pkg::IDX_GPIO_DIR:   rd_word = words.gpio_dir;
      // Set word reads back as status
      pinmux_pkg::IDX_GPIO_ISTAT,
      pinmux_pkg::IDX_GPIO_ISET:  rd_word = words.gpio_istat;
      pinmux_pkg::IDX_GPIO_IMASK: rd_word = words.gpio_imask;
      // Unmapped and dropped words
      default:                    rd_word = '0;
    endcase
  end

  // Sampled in the cycle before ack, held while ack is high
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      reg_rdata <= '0;
    end else if (rd_capture) begin
      reg_rdata <= rd_word;
    end
  end

endmodule

// File: design/pinmux_reg.sv
`timescale 1ns/1ps

module pinmux_reg (
  input  logic                          mclk,
  input  logic                          h_reset_n,
  // Register bus
  input  logic                          reg_cs,
  input  logic                          reg_wr,
  input  logic [pinmux_pkg::ADDR_W-1:0] reg_addr,
  input  logic [pinmux_pkg::DATA_W-1:0] reg_wdata,
  input  logic [pinmux_pkg::BE_W-1:0]   reg_be,
  output logic [pinmux_pkg::DATA_W-1:0] reg_rdata,
  output logic                          reg_ack,
  // Interrupt sources
  input  logic [1:0]                    ext_intr_in,
  input  logic                          usb_intr,
  input  logic                          i2cm_intr,
  input  logic [2:0]                    timer_intr,
  // GPIO pins and events
  input  logic [pinmux_pkg::DATA_W-1:0] gpio_in_data,
  input  logic [pinmux_pkg::DATA_W-1:0] gpio_int_event,
  // Configuration out
  output pinmux_pkg::rst_ctrl_t         rst_ctrl,
  output pinmux_pkg::glbl_cfg_t         glbl_cfg,
  output pinmux_pkg::riscv_irq_t        riscv_irq,
  output pinmux_pkg::gpio_cfg_t         gpio_cfg,
  output logic                          gpio_intr
);

  pinmux_pkg::reg_wr_t          wr;
  logic [pinmux_pkg::IDX_W-1:0] rd_idx;
  logic                         rd_capture;
  // Driven field by field from both register blocks
  wire pinmux_pkg::reg_words_t  words;

  // --------------------
  // Decode
  // --------------------
  reg_bus_decode u_decode (
    .mclk       (mclk),
    .h_reset_n  (h_reset_n),
    .reg_cs     (reg_cs),
    .reg_wr     (reg_wr),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .reg_be     (reg_be),
    .reg_ack    (reg_ack),
    .wr         (wr),
    .rd_idx     (rd_idx),
    .rd_capture (rd_capture)
  );

  // --------------------
  // Register blocks
  // --------------------
  glbl_cfg_regs u_glbl (
    .mclk           (mclk),
    .h_reset_n      (h_reset_n),
    .wr             (wr),
    .ext_intr_in    (ext_intr_in),
    .usb_intr       (usb_intr),
    .i2cm_intr      (i2cm_intr),
    .timer_intr     (timer_intr),
    .gpio_intr      (gpio_intr),
    .rst_ctrl       (rst_ctrl),
    .glbl_cfg       (glbl_cfg),
    .riscv_irq      (riscv_irq),
    .chip_id_word   (words.chip_id),
    .glbl_ctrl_word (words.glbl_ctrl),
    .glbl_cfg_word  (words.glbl_cfg),
    .irq_mask_word  (words.irq_mask),
    .irq_stat_word  (words.irq_stat)
  );

  gpio_regs u_gpio (
    .mclk            (mclk),
    .h_reset_n       (h_reset_n),
    .wr              (wr),
    .gpio_in_data    (gpio_in_data),
    .gpio_int_event  (gpio_int_event),
    .gpio_cfg        (gpio_cfg),
    .gpio_intr       (gpio_intr),
    .gpio_in_word    (words.gpio_in),
    .gpio_out_word   (words.gpio_out),
    .gpio_dir_word   (words.gpio_dir),
    .gpio_istat_word (words.gpio_istat),
    .gpio_imask_word (words.gpio_imask)
  );

  // --------------------
  // Read data
  // --------------------
  reg_read_mux u_rd_mux (
    .mclk       (mclk),
    .h_reset_n  (h_reset_n),
    .rd_idx     (rd_idx),
    .rd_capture (rd_capture),
    .words      (words),
    .reg_rdata  (reg_rdata)
  );

endmodule

// File: tb/tb_pinmux_reg.sv
`timescale 1ns/1ps

module tb_pinmux_reg;

  localparam int CLK_PERIOD = 40;
  localparam int DRV_DLY    = 2;
  localparam int SMP_DLY    = 1;
  localparam int RST_CYCLES = 10;
  localparam int ACK_WAIT   = 8;
  // Tests need roughly 450 cycles
  localparam int TIMEOUT_CYCLES = 2000;
  localparam logic [31:0] EXP_CHIP_ID = 32'h8268_2301;

  logic        mclk;
  logic        h_reset_n;
  logic        reg_cs;
  logic        reg_wr;
  logic [7:0]  reg_addr;
  logic [31:0] reg_wdata;
  logic [3:0]  reg_be;
  logic [31:0] reg_rdata;
  logic        reg_ack;
  logic [1:0]  ext_intr_in;
  logic        usb_intr;
  logic        i2cm_intr;
  logic [2:0]  timer_intr;
  logic [31:0] gpio_in_data;
  logic [31:0] gpio_int_event;
  pinmux_pkg::rst_ctrl_t  rst_ctrl;
  pinmux_pkg::glbl_cfg_t  glbl_cfg;
  pinmux_pkg::riscv_irq_t riscv_irq;
  pinmux_pkg::gpio_cfg_t  gpio_cfg;
  logic        gpio_intr;

  logic [31:0] seed;
  int          errors = 0;
  int          err_mark;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          cycle_cnt = 0;
  string       test_name = "reset";

  // Expected register contents
  logic [31:0] word_m [12];
  logic [31:0] gstat_m;
  logic [7:0]  sw_lo_m;
  logic [7:0]  hw_m;
  logic [3:0]  sw_hi_m;

  pinmux_reg u_pinmux_reg (
    .mclk           (mclk),
    .h_reset_n      (h_reset_n),
    .reg_cs         (reg_cs),
    .reg_wr         (reg_wr),
    .reg_addr       (reg_addr),
    .reg_wdata      (reg_wdata),
    .reg_be         (reg_be),
    .reg_rdata      (reg_rdata),
    .reg_ack        (reg_ack),
    .ext_intr_in    (ext_intr_in),
    .usb_intr       (usb_intr),
    .i2cm_intr      (i2cm_intr),
    .timer_intr     (timer_intr),
    .gpio_in_data   (gpio_in_data),
    .gpio_int_event (gpio_int_event),
    .rst_ctrl       (rst_ctrl),
    .glbl_cfg       (glbl_cfg),
    .riscv_irq      (riscv_irq),
    .gpio_cfg       (gpio_cfg),
    .gpio_intr      (gpio_intr)
  );

  initial begin
    mclk = 1'b0;
    forever #(CLK_PERIOD/2) mclk = ~mclk;
  end

  // Hard stop if something hangs
  always @(posedge mclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Run stopped after %0d cycles before the tests finished", cycle_cnt);
      $display("Regression failed");
      $finish;
    end
  end

  // --------------------
  // Bus protocol checks
  // --------------------
  a_ack_single: assert property (@(posedge mclk) disable iff (!h_reset_n)
    reg_ack |=> !reg_ack)
    else begin
      $display("reg_ack stayed high for two cycles in test %s", test_name);
      errors++;
    end

  // Ack one cycle after the request rises
  a_ack_latency: assert property (@(posedge mclk) disable iff (!h_reset_n)
    $rose(reg_cs) |=> reg_ack)
    else begin
      $display("reg_ack missing one cycle after reg_cs rose in test %s", test_name);
      errors++;
    end

  // --------------------
  // Helpers
  // --------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic get_rand(output logic [31:0] r);
    seed = xorshift32(seed);
    r = seed;
  endtask

  function automatic logic [31:0] byte_mask(input logic [3:0] be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  // Enabled lanes take new data, others keep old
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  be);
    return (old_w & ~byte_mask(be)) | (new_w & byte_mask(be));
  endfunction

  task automatic compare_word(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
    assert (act === exp)
      else begin
        $display("ERROR %s %s expected %h actual %h", test_name, what, exp, act);
        errors++;
      end
  endtask

  // One bus access, held until ack, released the cycle after
  task automatic do_access(input logic wr, input logic [4:0] idx,
                           input logic [31:0] data, input logic [3:0] be,
                           output logic [31:0] rdata);
    int wait_cnt;
    wait_cnt = 0;
    @(posedge mclk);
    #DRV_DLY;
    reg_cs    = 1'b1;
    reg_wr    = wr;
    reg_addr  = {1'b0, idx, 2'b00};
    reg_wdata = data;
    reg_be    = be;
    do begin
      @(posedge mclk);
      #SMP_DLY;
      wait_cnt++;
    end while (!reg_ack && wait_cnt < ACK_WAIT);
    if (!reg_ack) begin
      $display("No acknowledge for word %0d in test %s", idx, test_name);
      errors++;
    end
    compare_word("ack latency", 32'd1, wait_cnt);
    rdata = reg_rdata;
    @(posedge mclk);
    #DRV_DLY;
    reg_cs = 1'b0;
    reg_wr = 1'b0;
  endtask

  task automatic write_word(input logic [4:0] idx, input logic [31:0] data,
                            input logic [3:0] be);
    logic [31:0] unused;
    do_access(1'b1, idx, data, be, unused);
  endtask

  task automatic read_word(input logic [4:0] idx, output logic [31:0] data);
    do_access(1'b0, idx, 32'h0, 4'h0, data);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_mark  = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != err_mark) begin
      tests_failed++;
      $display("Test %s failed with %0d errors", test_name, errors - err_mark);
    end else begin
      $display("Test %s passed", test_name);
    end
  endtask

  // Sticky sources are {ext[1:0], usb, i2cm, timer[2:0]}
  task automatic pulse_hw_irq(input logic [6:0] src);
    @(posedge mclk);
    #DRV_DLY;
    {ext_intr_in, usb_intr, i2cm_intr, timer_intr} = src;
    @(posedge mclk);
    #DRV_DLY;
    {ext_intr_in, usb_intr, i2cm_intr, timer_intr} = '0;
  endtask

  task automatic pulse_gpio_event(input logic [31:0] ev);
    @(posedge mclk);
    #DRV_DLY;
    gpio_int_event = ev;
    @(posedge mclk);
    #DRV_DLY;
    gpio_int_event = '0;
  endtask

  // Status word 4 model, byte 1 is write-1-clear
  task automatic write_irq_stat(input logic [31:0] data, input logic [3:0] be);
    write_word(pinmux_pkg::IDX_IRQ_STAT, data, be);
    if (be[0]) sw_lo_m = data[7:0];
    if (be[1]) hw_m = hw_m & ~data[15:8];
    if (be[2]) sw_hi_m = data[19:16];
  endtask

  task automatic gpio_state();
    logic [31:0] rd;
    read_word(pinmux_pkg::IDX_GPIO_ISTAT, rd);
    compare_word("gpio status", gstat_m, rd);
    read_word(pinmux_pkg::IDX_GPIO_ISET, rd);
    compare_word("gpio set readback", gstat_m, rd);
    compare_word("gpio_intr", {31'h0, |(gstat_m & word_m[11])}, {31'h0, gpio_intr});
  endtask

  task automatic glbl_state();
    logic [31:0] rd;
    logic [31:0] stat;
    logic [31:0] ms;
    stat = {12'h0, sw_hi_m, hw_m, sw_lo_m};
    read_word(pinmux_pkg::IDX_IRQ_MASK, rd);
    compare_word("irq mask", word_m[3], rd);
    read_word(pinmux_pkg::IDX_IRQ_STAT, rd);
    compare_word("irq status", stat, rd);
    // Lines 15:0, soft bit 16, user 19:17
    ms = word_m[3] & stat;
    compare_word("riscv_irq", {12'h0, ms[15:0], ms[16], ms[19:17]}, {12'h0, riscv_irq});
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic reset_defaults();
    logic [31:0] rd;
    begin_test("reset_defaults");
    compare_word("reg_ack", 32'h0, {31'h0, reg_ack});
    compare_word("rst_ctrl", 32'h0, {23'h0, rst_ctrl});
    compare_word("riscv_irq", 32'h0, {12'h0, riscv_irq});
    compare_word("gpio_intr", 32'h0, {31'h0, gpio_intr});
    read_word(5'd0, rd);
    compare_word("chip id", EXP_CHIP_ID, rd);
    read_word(5'd20, rd);
    compare_word("unmapped word 20", 32'h0, rd);
    // Dropped word
    read_word(5'd8, rd);
    compare_word("dropped word 8", 32'h0, rd);
    end_test();
  endtask

  task automatic byte_lane_writes();
    logic [4:0]  rw_idx [5];
    logic [31:0] r;
    logic [31:0] b;
    logic [31:0] rd;
    logic [31:0] c;
    logic [31:0] f;
    begin_test("byte_lane_writes");
    rw_idx[0] = pinmux_pkg::IDX_GLBL_CTRL;
    rw_idx[1] = pinmux_pkg::IDX_GLBL_CFG;
    rw_idx[2] = pinmux_pkg::IDX_IRQ_MASK;
    rw_idx[3] = pinmux_pkg::IDX_GPIO_OUT;
    rw_idx[4] = pinmux_pkg::IDX_GPIO_DIR;
    for (int round = 0; round < 4; round++) begin
      for (int k = 0; k < 5; k++) begin
        get_rand(r);
        get_rand(b);
        write_word(rw_idx[k], r, b[3:0]);
        word_m[rw_idx[k]] = merge_bytes(word_m[rw_idx[k]], r, b[3:0]);
        read_word(rw_idx[k], rd);
        compare_word($sformatf("word %0d", rw_idx[k]), word_m[rw_idx[k]], rd);
      end
      // Reset fields, bit 0 up to bit 6 then bits 9:8
      c = word_m[1];
      compare_word("rst_ctrl", {23'h0, c[9:8], c[0], c[1], c[2], c[3], c[4], c[5], c[6]},
                   {23'h0, rst_ctrl});
      f = word_m[2];
      compare_word("glbl_cfg", {6'h0, f[9:0], f[31:16]}, {6'h0, glbl_cfg});
      compare_word("gpio out_data", word_m[6], gpio_cfg.out_data);
      compare_word("gpio dir_sel", word_m[7], gpio_cfg.dir_sel);
    end
    end_test();
  endtask

  task automatic gpio_input_sync();
    logic [31:0] r;
    logic [31:0] rd;
    begin_test("gpio_input_sync");
    get_rand(r);
    @(posedge mclk);
    #DRV_DLY;
    gpio_in_data = r;
    // Two synchroniser flops
    @(posedge mclk);
    @(posedge mclk);
    #SMP_DLY;
    compare_word("prev_indata", r, gpio_cfg.prev_indata);
    // Capture flop
    @(posedge mclk);
    #SMP_DLY;
    compare_word("data_in", r, gpio_cfg.data_in);
    read_word(pinmux_pkg::IDX_GPIO_IN, rd);
    compare_word("word 5", r, rd);
    end_test();
  endtask

  task automatic gpio_interrupts();
    logic [31:0] r;
    logic [31:0] b;
    begin_test("gpio_interrupts");
    get_rand(r);
    write_word(pinmux_pkg::IDX_GPIO_IMASK, r, 4'hf);
    word_m[11] = r;
    gpio_state();
    get_rand(r);
    pulse_gpio_event(r);
    gstat_m = gstat_m | r;
    gpio_state();
    get_rand(r);
    write_word(pinmux_pkg::IDX_GPIO_ISET, r, 4'hf);
    gstat_m = gstat_m | r;
    gpio_state();
    // Clear only the enabled lanes
    repeat (3) begin
      get_rand(b);
      write_word(pinmux_pkg::IDX_GPIO_ISTAT, 32'hffff_ffff, b[3:0]);
      gstat_m = gstat_m & ~byte_mask(b[3:0]);
      gpio_state();
    end
    // Top lane alone, byte 2 must survive
    write_word(pinmux_pkg::IDX_GPIO_ISET, 32'hffff_ffff, 4'hf);
    gstat_m = 32'hffff_ffff;
    write_word(pinmux_pkg::IDX_GPIO_ISTAT, 32'hffff_ffff, 4'b1000);
    gstat_m = 32'h00ff_ffff;
    gpio_state();
    write_word(pinmux_pkg::IDX_GPIO_ISTAT, 32'hffff_ffff, 4'hf);
    gstat_m = '0;
    gpio_state();
    end_test();
  endtask

  task automatic global_interrupts();
    logic [31:0] r;
    logic [31:0] b;
    begin_test("global_interrupts");
    // Drop anything latched from the GPIO test
    write_irq_stat(32'h0000_ff00, 4'b0010);
    get_rand(r);
    write_word(pinmux_pkg::IDX_IRQ_MASK, r, 4'hf);
    word_m[3] = r;
    glbl_state();
    repeat (3) begin
      get_rand(r);
      pulse_hw_irq(r[6:0]);
      hw_m = hw_m | {1'b0, r[6:0]};
      glbl_state();
    end
    // Zero in byte 1 leaves sticky bits alone
    get_rand(r);
    write_irq_stat(r & 32'hffff_00ff, 4'hf);
    glbl_state();
    get_rand(r);
    write_irq_stat(r, 4'b0010);
    glbl_state();
    // GPIO interrupt lands in bit 15
    write_word(pinmux_pkg::IDX_GPIO_IMASK, 32'h1, 4'hf);
    word_m[11] = 32'h1;
    write_word(pinmux_pkg::IDX_GPIO_ISET, 32'h1, 4'hf);
    compare_word("gpio_intr set", 32'h1, {31'h0, gpio_intr});
    write_word(pinmux_pkg::IDX_GPIO_ISTAT, 32'h1, 4'hf);
    compare_word("gpio_intr clear", 32'h0, {31'h0, gpio_intr});
    hw_m[7] = 1'b1;
    glbl_state();
    write_irq_stat(32'h0000_ff00, 4'b0010);
    glbl_state();
    // Mixed pulses and partial writes
    repeat (3) begin
      get_rand(r);
      get_rand(b);
      pulse_hw_irq(b[14:8]);
      hw_m = hw_m | {1'b0, b[14:8]};
      write_irq_stat(r, b[3:0]);
      glbl_state();
    end
    end_test();
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    h_reset_n      = 1'b0;
    reg_cs         = 1'b0;
    reg_wr         = 1'b0;
    reg_addr       = '0;
    reg_wdata      = '0;
    reg_be         = '0;
    ext_intr_in    = '0;
    usb_intr       = 1'b0;
    i2cm_intr      = 1'b0;
    timer_intr     = '0;
    gpio_in_data   = '0;
    gpio_int_event = '0;
    seed           = 32'hf78e4faa;
    for (int i = 0; i < 12; i++) begin
      word_m[i] = '0;
    end
    gstat_m = '0;
    sw_lo_m = '0;
    hw_m    = '0;
    sw_hi_m = '0;
    repeat (RST_CYCLES) @(posedge mclk);
    #DRV_DLY;
    h_reset_n = 1'b1;
    reset_defaults();
    byte_lane_writes();
    gpio_input_sync();
    gpio_interrupts();
    global_interrupts();
    repeat (2) @(posedge mclk);
    $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
common/pinmux_pkg.sv
design/reg_bus_decode.sv
glbl_cfg/glbl_cfg_regs.sv
gpio/gpio_regs.sv
design/reg_read_mux.sv
design/pinmux_reg.sv
tb/tb_pinmux_reg.sv

// File: Bender.yml
package:
  name: pinmux_reg

sources:
  # Shared package first
  - common/pinmux_pkg.sv
  # Register blocks and top level
  - design/reg_bus_decode.sv
  - glbl_cfg/glbl_cfg_regs.sv
  - gpio/gpio_regs.sv
  - design/reg_read_mux.sv
  - design/pinmux_reg.sv
  # Simulation only
  - target: test
    files:
      - tb/tb_pinmux_reg.sv
